/* bcpu16_alu.f */
+incdir+dv
source/bcpu16_isa_pkg.sv
source/bcpu16_pipe_pkg.sv
source/alu_issue_stage.sv
source/alu_execute_stage.sv
source/alu_writeback_stage.sv
source/bcpu16_alu.sv
dv/bcpu16_alu_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = bcpu16_alu_tb
FILELIST = bcpu16_alu.f

BUILD    = build
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); false)
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

/* dv/bcpu16_alu_vectors.svh */
`ifndef BCPU16_ALU_VECTORS_SVH
`define BCPU16_ALU_VECTORS_SVH

    // ========================================================================
    // ALU pipeline vectors, one issue slot per row
    // ========================================================================

    typedef enum logic [1:0] {K_IDLE, K_ALU, K_CALL, K_MEM} strobe_kind_t;

    typedef struct packed {
        strobe_kind_t             kind;                 // which strobe the row raises
        bcpu16_isa_pkg::alu_op_t  op;
        bcpu16_isa_pkg::word_t    a;
        bcpu16_isa_pkg::word_t    b;
        bcpu16_isa_pkg::pc_t      pc;
        bcpu16_isa_pkg::flags_t   flags;                // FLAGS_IN of the slot
        bcpu16_isa_pkg::word_t    mem_data;             // read data, driven two slots later
        bcpu16_isa_pkg::word_t    exp_out;
        bcpu16_isa_pkg::flags_t   exp_flags;            // {V, S, Z, C}
        logic                     out_dc;               // result not checked
    } vector_t;

    localparam bcpu16_isa_pkg::alu_op_t OP_ADD    = bcpu16_isa_pkg::ADD;
    localparam bcpu16_isa_pkg::alu_op_t OP_ADC    = bcpu16_isa_pkg::ADC;
    localparam bcpu16_isa_pkg::alu_op_t OP_SUB    = bcpu16_isa_pkg::SUB;
    localparam bcpu16_isa_pkg::alu_op_t OP_SBC    = bcpu16_isa_pkg::SBC;
    localparam bcpu16_isa_pkg::alu_op_t OP_AND    = bcpu16_isa_pkg::AND;
    localparam bcpu16_isa_pkg::alu_op_t OP_ANDN   = bcpu16_isa_pkg::ANDN;
    localparam bcpu16_isa_pkg::alu_op_t OP_OR     = bcpu16_isa_pkg::OR;
    localparam bcpu16_isa_pkg::alu_op_t OP_XOR    = bcpu16_isa_pkg::XOR;
    localparam bcpu16_isa_pkg::alu_op_t OP_MUL    = bcpu16_isa_pkg::MUL;
    localparam bcpu16_isa_pkg::alu_op_t OP_MULHUU = bcpu16_isa_pkg::MULHUU;
    localparam bcpu16_isa_pkg::alu_op_t OP_MULHSU = bcpu16_isa_pkg::MULHSU;
    localparam bcpu16_isa_pkg::alu_op_t OP_MULHSS = bcpu16_isa_pkg::MULHSS;

    localparam int NUM_ROWS   = 34;
    localparam int STALL_FROM = 20;                     // random CE from this row on
    localparam int ROW_BITS   = $clog2(NUM_ROWS);

    // kind, op, a, b, pc, flags_in, mem_data, expected out, expected flags, out don't-care
    localparam vector_t VECTORS [NUM_ROWS] = '{
        '{K_ALU,  OP_ADD,    16'h7fff, 16'h0001, 12'h000, 4'h0, 16'h0000, 16'h8000, 4'hc, 1'b0},
        '{K_ALU,  OP_SUB,    16'h0000, 16'h0001, 12'h000, 4'h0, 16'h0000, 16'hffff, 4'h5, 1'b0},
        '{K_ALU,  OP_ADD,    16'h0001, 16'h0001, 12'h000, 4'h1, 16'h0000, 16'h0002, 4'h0, 1'b0},
        '{K_ALU,  OP_ADC,    16'h0001, 16'h0001, 12'h000, 4'h1, 16'h0000, 16'h0003, 4'h0, 1'b0},
        '{K_ALU,  OP_ADC,    16'hffff, 16'h0000, 12'h000, 4'h1, 16'h0000, 16'h0000, 4'h3, 1'b0},
        '{K_ALU,  OP_SBC,    16'h0005, 16'h0003, 12'h000, 4'hf, 16'h0000, 16'h0001, 4'h0, 1'b0},
        '{K_ALU,  OP_SBC,    16'h0000, 16'h0000, 12'h000, 4'h1, 16'h0000, 16'hffff, 4'h5, 1'b0},
        '{K_ALU,  OP_SUB,    16'h0005, 16'h0005, 12'h000, 4'hd, 16'h0000, 16'h0000, 4'h2, 1'b0},
        '{K_ALU,  OP_ADD,    16'h8000, 16'h8000, 12'h000, 4'h0, 16'h0000, 16'h0000, 4'hb, 1'b0},
        '{K_ALU,  OP_AND,    16'hf0f0, 16'h0ff0, 12'h000, 4'hf, 16'h0000, 16'h00f0, 4'h9, 1'b0},
        '{K_ALU,  OP_ANDN,   16'hf0f0, 16'h0ff0, 12'h000, 4'h0, 16'h0000, 16'hf000, 4'h4, 1'b0},
        '{K_ALU,  OP_OR,     16'h0000, 16'h0000, 12'h000, 4'h9, 16'h0000, 16'h0000, 4'hb, 1'b0},
        '{K_ALU,  OP_XOR,    16'ha5a5, 16'hffff, 12'h000, 4'h6, 16'h0000, 16'h5a5a, 4'h0, 1'b0},
        '{K_ALU,  OP_MUL,    16'hffff, 16'hffff, 12'h000, 4'h5, 16'h0000, 16'h0001, 4'h5, 1'b0},
        '{K_ALU,  OP_MULHUU, 16'hffff, 16'hffff, 12'h000, 4'ha, 16'h0000, 16'hfffe, 4'ha, 1'b0},
        '{K_ALU,  OP_MULHSU, 16'hffff, 16'hffff, 12'h000, 4'h3, 16'h0000, 16'hffff, 4'h3, 1'b0},
        '{K_ALU,  OP_MULHSS, 16'hffff, 16'hffff, 12'h000, 4'hc, 16'h0000, 16'h0000, 4'hc, 1'b0},
        '{K_CALL, OP_ADD,    16'hffff, 16'h0000, 12'habc, 4'h7, 16'h0000, 16'h0abc, 4'h7, 1'b0},
        '{K_MEM,  OP_ADD,    16'h0000, 16'h0000, 12'h000, 4'h3, 16'hbeef, 16'hbeef, 4'h3, 1'b0},
        '{K_IDLE, OP_ADD,    16'h0000, 16'h0000, 12'h000, 4'he, 16'h0000, 16'h0000, 4'he, 1'b1},
        '{K_ALU,  OP_SBC,    16'h8000, 16'h0001, 12'h000, 4'h0, 16'h0000, 16'h7fff, 4'h8, 1'b0},
        '{K_MEM,  OP_ADD,    16'h0000, 16'h0000, 12'h000, 4'hc, 16'hc0de, 16'hc0de, 4'hc, 1'b0},
        '{K_ALU,  OP_MULHSS, 16'h8000, 16'h8000, 12'h000, 4'h0, 16'h0000, 16'h4000, 4'h0, 1'b0},
        '{K_ALU,  OP_XOR,    16'h1234, 16'h1234, 12'h000, 4'h8, 16'h0000, 16'h0000, 4'ha, 1'b0},
        '{K_CALL, OP_ADD,    16'h0000, 16'h0000, 12'h123, 4'h0, 16'h0000, 16'h0123, 4'h0, 1'b0},
        '{K_MEM,  OP_ADD,    16'h0000, 16'h0000, 12'h000, 4'h1, 16'h5a3c, 16'h5a3c, 4'h1, 1'b0},
        '{K_ALU,  OP_ADC,    16'h1234, 16'h4321, 12'h000, 4'h0, 16'h0000, 16'h5555, 4'h0, 1'b0},
        '{K_ALU,  OP_MUL,    16'h1234, 16'h0010, 12'h000, 4'h2, 16'h0000, 16'h2340, 4'h2, 1'b0},
        '{K_ALU,  OP_MULHSU, 16'h8000, 16'h0002, 12'h000, 4'h6, 16'h0000, 16'hffff, 4'h6, 1'b0},
        '{K_ALU,  OP_MULHUU, 16'h8000, 16'h0002, 12'h000, 4'h9, 16'h0000, 16'h0001, 4'h9, 1'b0},
        '{K_IDLE, OP_ADD,    16'h0000, 16'h0000, 12'h000, 4'h5, 16'h0000, 16'h0000, 4'h5, 1'b1},
        '{K_ALU,  OP_ADD,    16'hffff, 16'h0001, 12'h000, 4'h0, 16'h0000, 16'h0000, 4'h3, 1'b0},
        '{K_MEM,  OP_ADD,    16'h0000, 16'h0000, 12'h000, 4'h0, 16'h8001, 16'h8001, 4'h0, 1'b0},
        '{K_ALU,  OP_ANDN,   16'hffff, 16'h00ff, 12'h000, 4'h1, 16'h0000, 16'hff00, 4'h5, 1'b0}
    };

`endif

/* dv/bcpu16_alu_tb.sv */
module bcpu16_alu_tb;

    `include "bcpu16_alu_vectors.svh"

    localparam int NUM_SLOTS  = NUM_ROWS + 2;           // two idle slots drain the pipe
    localparam int MAX_CYCLES = 2 * NUM_ROWS + 20;

    logic                    CLK;
    logic                    RESET;
    logic                    ce;
    logic                    alu_en;
    logic                    call_en;
    logic                    mem_rd_en;
    bcpu16_isa_pkg::alu_op_t alu_op;
    bcpu16_isa_pkg::flags_t  flags_in;
    bcpu16_isa_pkg::word_t   a_in;
    bcpu16_isa_pkg::word_t   b_in;
    bcpu16_isa_pkg::pc_t     pc_in;
    bcpu16_isa_pkg::word_t   mem_rd_data;
    bcpu16_isa_pkg::word_t   alu_out;
    bcpu16_isa_pkg::flags_t  flags_out;

    int unsigned out_errors  = 0;                       // ALU_OUT mismatches
    int unsigned flag_errors = 0;                       // FLAGS_OUT mismatches
    int unsigned cycle_count = 0;

    bcpu16_alu uut (
        .CLK         (CLK),
        .RESET       (RESET),
        .CE          (ce),
        .ALU_EN      (alu_en),
        .CALL_EN     (call_en),
        .MEM_RD_EN   (mem_rd_en),
        .ALU_OP      (alu_op),
        .FLAGS_IN    (flags_in),
        .A_IN        (a_in),
        .B_IN        (b_in),
        .PC_IN       (pc_in),
        .MEM_RD_DATA (mem_rd_data),
        .ALU_OUT     (alu_out),
        .FLAGS_OUT   (flags_out)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // watchdog
    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("errors: ALU_OUT %0d, FLAGS_OUT %0d", out_errors, flag_errors);
            $display("timeout: the vector table did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // ========================================================================
    // stimulus and checks
    // ========================================================================

    // slots past the table are idle with flags 0
    task automatic drive_slot(input int slot, input logic ce_val);
        vector_t row;
        row = '0;
        if (slot < NUM_ROWS) begin
            row = VECTORS[ROW_BITS'(slot)];
        end
        ce        = ce_val;
        alu_en    = (row.kind == K_ALU);
        call_en   = (row.kind == K_CALL);
        mem_rd_en = (row.kind == K_MEM);
        alu_op    = row.op;
        a_in      = row.a;
        b_in      = row.b;
        pc_in     = row.pc;
        flags_in  = row.flags;
        mem_rd_data = '0;
        if (slot >= 2) begin
            mem_rd_data = VECTORS[ROW_BITS'(slot - 2)].mem_data;   // read issued two slots ago
        end
    endtask

    task automatic check_row(input int idx);
        vector_t row;
        row = VECTORS[ROW_BITS'(idx)];
        if (!row.out_dc && alu_out !== row.exp_out) begin
            $display("mismatch ALU_OUT row %0d: got %h expected %h", idx, alu_out, row.exp_out);
            out_errors++;
        end
        if (flags_out !== row.exp_flags) begin
            $display("mismatch FLAGS_OUT row %0d: got %h expected %h",
                     idx, flags_out, row.exp_flags);
            flag_errors++;
        end
    endtask

    // CE low edge must leave both outputs alone
    task automatic check_hold(input bcpu16_isa_pkg::word_t  held_out,
                              input bcpu16_isa_pkg::flags_t held_flags);
        if (alu_out !== held_out) begin
            $display("mismatch ALU_OUT on stall: got %h expected %h", alu_out, held_out);
            out_errors++;
        end
        if (flags_out !== held_flags) begin
            $display("mismatch FLAGS_OUT on stall: got %h expected %h", flags_out, held_flags);
            flag_errors++;
        end
    endtask

    initial begin
        logic                   ce_next;
        int                     slot;
        bcpu16_isa_pkg::word_t  last_out;
        bcpu16_isa_pkg::flags_t last_flags;
        void'($urandom(32'h2cec0dd7));
        RESET = 1'b1;
        ce    = 1'b1;
        alu_en      = 1'b0;
        call_en     = 1'b0;
        mem_rd_en   = 1'b0;
        alu_op      = OP_ADD;
        flags_in    = '0;
        a_in        = '0;
        b_in        = '0;
        pc_in       = '0;
        mem_rd_data = '0;
        repeat (2) @(posedge CLK);
        #1;
        RESET = 1'b0;
        if (alu_out !== '0) begin
            $display("mismatch ALU_OUT after reset: got %h expected 0000", alu_out);
            out_errors++;
        end
        if (flags_out !== '0) begin
            $display("mismatch FLAGS_OUT after reset: got %h expected 0", flags_out);
            flag_errors++;
        end
        last_out   = alu_out;
        last_flags = flags_out;
        slot       = 0;
        while (slot < NUM_SLOTS) begin
            ce_next = 1'b1;
            if (slot >= STALL_FROM) begin
                ce_next = (($urandom % 4) != 0);        // about one stall in four
            end
            drive_slot(slot, ce_next);
            @(posedge CLK);
            #1;
            if (ce_next) begin
                if (slot >= 2) begin
                    check_row(slot - 2);                // E3 of the row two slots back
                end
                slot++;
            end else begin
                check_hold(last_out, last_flags);
            end
            last_out   = alu_out;
            last_flags = flags_out;
        end
        $display("errors: ALU_OUT %0d, FLAGS_OUT %0d", out_errors, flag_errors);
        if (out_errors == 0 && flag_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* source/bcpu16_alu.sv */
module bcpu16_alu (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     CE,                // global enable, the only stall
    input  logic                     ALU_EN,
    input  logic                     CALL_EN,
    input  logic                     MEM_RD_EN,
    input  bcpu16_isa_pkg::alu_op_t  ALU_OP,
    input  bcpu16_isa_pkg::flags_t   FLAGS_IN,
    input  bcpu16_isa_pkg::word_t    A_IN,
    input  bcpu16_isa_pkg::word_t    B_IN,
    input  bcpu16_isa_pkg::pc_t      PC_IN,
    input  bcpu16_isa_pkg::word_t    MEM_RD_DATA,       // two CE edges after the read
    output bcpu16_isa_pkg::word_t    ALU_OUT,           // three CE edges after issue
    output bcpu16_isa_pkg::flags_t   FLAGS_OUT
);

    bcpu16_pipe_pkg::issue_t issue_w;                   // E1 register
    bcpu16_pipe_pkg::exec_t  exec_w;                    // E2 register

    alu_issue_stage u_issue (
        .CLK       (CLK),
        .RESET     (RESET),
        .CE        (CE),
        .alu_en    (ALU_EN),
        .call_en   (CALL_EN),
        .mem_rd_en (MEM_RD_EN),
        .op        (ALU_OP),
        .flags_in  (FLAGS_IN),
        .a_in      (A_IN),
        .b_in      (B_IN),
        .pc_in     (PC_IN),
        .issue_q   (issue_w)
    );

    alu_execute_stage u_execute (
        .CLK       (CLK),
        .RESET     (RESET),
        .CE        (CE),
        .issue_d   (issue_w),
        .exec_q    (exec_w)
    );

    alu_writeback_stage u_writeback (
        .CLK         (CLK),
        .RESET       (RESET),
        .CE          (CE),
        .mem_rd_data (MEM_RD_DATA),
        .exec_d      (exec_w),
        .alu_out     (ALU_OUT),                         // E3 register
        .flags_out   (FLAGS_OUT)
    );

endmodule

/* source/alu_writeback_stage.sv */
module alu_writeback_stage (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     CE,
    input  bcpu16_isa_pkg::word_t    mem_rd_data,       // valid the cycle before E3
    input  bcpu16_pipe_pkg::exec_t   exec_d,
    output bcpu16_isa_pkg::word_t    alu_out,
    output bcpu16_isa_pkg::flags_t   flags_out
);

    bcpu16_isa_pkg::word_t   result;                    // selected result word
    bcpu16_isa_pkg::flags_t  new_flags;                 // flags computed from raw
    bcpu16_isa_pkg::flags_t  merged_flags;              // new where masked, else old

    // ========================================================================
    // result select
    // ========================================================================

    always_comb begin
        case (exec_d.sel)
            bcpu16_pipe_pkg::SEL_HIGH: begin
                result = exec_d.raw[2*bcpu16_isa_pkg::DATA_WIDTH-1:bcpu16_isa_pkg::DATA_WIDTH];
            end
            bcpu16_pipe_pkg::SEL_MEM: begin
                result = mem_rd_data;                   // read data sampled at E3
            end
            default: begin
                result = exec_d.raw[bcpu16_isa_pkg::DATA_WIDTH-1:0];
            end
        endcase
    end

    // ========================================================================
    // flags
    // ========================================================================

    // carry from bit 17 of the extended sum
    assign new_flags[bcpu16_isa_pkg::FLAG_C] = exec_d.raw[bcpu16_isa_pkg::DATA_WIDTH+1];
    assign new_flags[bcpu16_isa_pkg::FLAG_Z] =
        (exec_d.raw[bcpu16_isa_pkg::DATA_WIDTH-1:0] == '0);
    assign new_flags[bcpu16_isa_pkg::FLAG_S] = exec_d.raw[bcpu16_isa_pkg::DATA_WIDTH-1];
    // overflow when the sign bit and the extension bit disagree
    assign new_flags[bcpu16_isa_pkg::FLAG_V] =
        exec_d.raw[bcpu16_isa_pkg::DATA_WIDTH-1] != exec_d.raw[bcpu16_isa_pkg::DATA_WIDTH];

    assign merged_flags = (new_flags & exec_d.update_mask)
                        | (exec_d.flags_in & ~exec_d.update_mask);   // idle slot keeps flags_in

    always_ff @(posedge CLK) begin
        if (RESET) begin
            alu_out   <= '0;
            flags_out <= '0;
        end else if (CE) begin                          // outputs hold while CE low
            alu_out   <= result;
            flags_out <= merged_flags;
        end
    end

endmodule

/* source/alu_execute_stage.sv */
module alu_execute_stage (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     CE,
    input  bcpu16_pipe_pkg::issue_t  issue_d,
    output bcpu16_pipe_pkg::exec_t   exec_q
);

    bcpu16_isa_pkg::dword_t  a_w;                       // a zero extended to 32 bits
    bcpu16_isa_pkg::dword_t  b_w;                       // b zero extended to 32 bits
    bcpu16_isa_pkg::dword_t  c_w;                       // carry as a 32 bit addend
    logic signed [33:0]      product;                   // full 17x17 product
    bcpu16_pipe_pkg::exec_t  exec_d;

    assign a_w = bcpu16_isa_pkg::dword_t'(issue_d.a);
    assign b_w = bcpu16_isa_pkg::dword_t'(issue_d.b);
    assign c_w = bcpu16_isa_pkg::dword_t'(issue_d.carry_in);

    // extension bit is zero for unsigned halves, so one signed multiplier covers all
    assign product = $signed(issue_d.a) * $signed(issue_d.b);

    // ========================================================================
    // function unit
    // ========================================================================

    always_comb begin
        exec_d.sel         = issue_d.sel;               // controls ride along
        exec_d.flags_in    = issue_d.flags_in;
        exec_d.update_mask = issue_d.update_mask;
        case (issue_d.fn)
            bcpu16_pipe_pkg::FN_ADD:  exec_d.raw = a_w + b_w + c_w;   // C lands in bit 17
            bcpu16_pipe_pkg::FN_SUB:  exec_d.raw = a_w - b_w - c_w;   // borrow in bit 17
            bcpu16_pipe_pkg::FN_AND:  exec_d.raw = a_w & b_w;
            bcpu16_pipe_pkg::FN_ANDN: exec_d.raw = a_w & ~b_w;
            bcpu16_pipe_pkg::FN_OR:   exec_d.raw = a_w | b_w;
            bcpu16_pipe_pkg::FN_XOR:  exec_d.raw = a_w ^ b_w;
            bcpu16_pipe_pkg::FN_MUL:  exec_d.raw = product[31:0];     // top 2 bits dropped
            default:                  exec_d.raw = a_w;               // FN_PASS
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            exec_q <= '0;
        end else if (CE) begin
            exec_q <= exec_d;
        end
    end

    // issue decode only feeds the carry into add and subtract
    a_pass_no_carry: assert property (@(posedge CLK) disable iff (RESET)
        (issue_d.fn == bcpu16_pipe_pkg::FN_PASS) |-> !issue_d.carry_in);

endmodule

/* source/alu_issue_stage.sv */
module alu_issue_stage (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     CE,
    input  logic                     alu_en,            // ALU op strobe
    input  logic                     call_en,           // call strobe
    input  logic                     mem_rd_en,         // memory read strobe
    input  bcpu16_isa_pkg::alu_op_t  op,
    input  bcpu16_isa_pkg::flags_t   flags_in,
    input  bcpu16_isa_pkg::word_t    a_in,
    input  bcpu16_isa_pkg::word_t    b_in,
    input  bcpu16_isa_pkg::pc_t      pc_in,
    output bcpu16_pipe_pkg::issue_t  issue_q
);

    bcpu16_pipe_pkg::issue_t issue_d;                   // next issue record
    logic                    a_signed;                  // extend a with its sign
    logic                    b_signed;                  // extend b with its sign

    // unsigned extension only for the unsigned multiply halves
    assign a_signed = (op != bcpu16_isa_pkg::MUL) && (op != bcpu16_isa_pkg::MULHUU);
    assign b_signed = a_signed && (op != bcpu16_isa_pkg::MULHSU);

    // ========================================================================
    // decode
    // ========================================================================

    always_comb begin
        issue_d          = '0;                          // idle slot by default
        issue_d.flags_in = flags_in;                    // always carried for merge
        issue_d.a        = {a_signed & a_in[bcpu16_isa_pkg::DATA_WIDTH-1], a_in};
        issue_d.b        = {b_signed & b_in[bcpu16_isa_pkg::DATA_WIDTH-1], b_in};
        if (call_en) begin
            issue_d.fn = bcpu16_pipe_pkg::FN_PASS;      // return address out
            issue_d.a  = bcpu16_isa_pkg::ext_word_t'(pc_in);  // zero extended PC
        end else if (mem_rd_en) begin
            issue_d.fn  = bcpu16_pipe_pkg::FN_PASS;
            issue_d.sel = bcpu16_pipe_pkg::SEL_MEM;     // word comes from memory at E3
        end else if (alu_en) begin
            case (op)
                bcpu16_isa_pkg::ADD,
                bcpu16_isa_pkg::ADC: begin
                    issue_d.fn          = bcpu16_pipe_pkg::FN_ADD;
                    issue_d.update_mask = bcpu16_isa_pkg::FLAGS_ARITH;
                end
                bcpu16_isa_pkg::SUB,
                bcpu16_isa_pkg::SBC: begin
                    issue_d.fn          = bcpu16_pipe_pkg::FN_SUB;
                    issue_d.update_mask = bcpu16_isa_pkg::FLAGS_ARITH;
                end
                bcpu16_isa_pkg::AND: begin
                    issue_d.fn          = bcpu16_pipe_pkg::FN_AND;
                    issue_d.update_mask = bcpu16_isa_pkg::FLAGS_LOGIC;
                end
                bcpu16_isa_pkg::ANDN: begin
                    issue_d.fn          = bcpu16_pipe_pkg::FN_ANDN;
                    issue_d.update_mask = bcpu16_isa_pkg::FLAGS_LOGIC;
                end
                bcpu16_isa_pkg::OR: begin
                    issue_d.fn          = bcpu16_pipe_pkg::FN_OR;
                    issue_d.update_mask = bcpu16_isa_pkg::FLAGS_LOGIC;
                end
                bcpu16_isa_pkg::XOR: begin
                    issue_d.fn          = bcpu16_pipe_pkg::FN_XOR;
                    issue_d.update_mask = bcpu16_isa_pkg::FLAGS_LOGIC;
                end
                bcpu16_isa_pkg::MUL: begin
                    issue_d.fn = bcpu16_pipe_pkg::FN_MUL;     // flags untouched
                end
                bcpu16_isa_pkg::MULHUU,
                bcpu16_isa_pkg::MULHSU,
                bcpu16_isa_pkg::MULHSS: begin
                    issue_d.fn  = bcpu16_pipe_pkg::FN_MUL;
                    issue_d.sel = bcpu16_pipe_pkg::SEL_HIGH;  // upper product word
                end
                default: ;                              // reserved, stays idle
            endcase
            if (op == bcpu16_isa_pkg::ADC || op == bcpu16_isa_pkg::SBC) begin
                issue_d.carry_in = flags_in[bcpu16_isa_pkg::FLAG_C];
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            issue_q <= '0;
        end else if (CE) begin                          // CE low holds the whole pipe
            issue_q <= issue_d;
        end
    end

    // strobes are exclusive in any enabled cycle
    a_one_strobe: assert property (@(posedge CLK) disable iff (RESET)
        CE |-> $onehot0({alu_en, call_en, mem_rd_en}));

    // opcodes 8..11 must never be issued
    a_no_reserved_op: assert property (@(posedge CLK) disable iff (RESET)
        (CE && alu_en) |-> (op[3:2] != 2'b10));

endmodule

/* source/bcpu16_pipe_pkg.sv */
package bcpu16_pipe_pkg;

    // ========================================================================
    // execute stage controls
    // ========================================================================

    // what the execute stage computes from a and b
    typedef enum logic [2:0] {
        FN_ADD  = 3'd0,                                 // a + b + carry_in
        FN_SUB  = 3'd1,                                 // a - b - carry_in
        FN_AND  = 3'd2,
        FN_ANDN = 3'd3,
        FN_OR   = 3'd4,
        FN_XOR  = 3'd5,
        FN_MUL  = 3'd6,                                 // 17x17 signed product
        FN_PASS = 3'd7                                  // a straight through
    } exec_fn_t;

    // where the writeback word comes from
    typedef enum logic [1:0] {
        SEL_LOW  = 2'd0,                                // raw[15:0]
        SEL_HIGH = 2'd1,                                // raw[31:16]
        SEL_MEM  = 2'd2                                 // memory read data
    } result_sel_t;

    // ========================================================================
    // stage records
    // ========================================================================

    // issue -> execute
    typedef struct packed {
        exec_fn_t                   fn;
        result_sel_t                sel;
        bcpu16_isa_pkg::ext_word_t  a;                  // extended operand a
        bcpu16_isa_pkg::ext_word_t  b;                  // extended operand b
        logic                       carry_in;           // C for ADC/SBC only
        bcpu16_isa_pkg::flags_t     flags_in;           // flags of the issue cycle
        bcpu16_isa_pkg::flags_t     update_mask;        // flags this op may change
    } issue_t;

    // execute -> writeback
    typedef struct packed {
        bcpu16_isa_pkg::dword_t     raw;                // 32 bit raw result
        result_sel_t                sel;
        bcpu16_isa_pkg::flags_t     flags_in;
        bcpu16_isa_pkg::flags_t     update_mask;
    } exec_t;

endpackage

/* source/bcpu16_isa_pkg.sv */
package bcpu16_isa_pkg;

    // ========================================================================
    // word sizes fixed by the instruction set
    // ========================================================================

    localparam int unsigned DATA_WIDTH = 16;            // data word
    localparam int unsigned ADDR_WIDTH = 12;            // program counter

    typedef logic [DATA_WIDTH-1:0]   word_t;            // register / bus word
    typedef logic [DATA_WIDTH:0]     ext_word_t;        // word plus sign or zero bit
    typedef logic [2*DATA_WIDTH-1:0] dword_t;           // raw execute result
    typedef logic [ADDR_WIDTH-1:0]   pc_t;              // program counter value

    // ========================================================================
    // status flags
    // ========================================================================

    typedef logic [3:0] flags_t;

    localparam int unsigned FLAG_C = 0;                 // carry / borrow
    localparam int unsigned FLAG_Z = 1;                 // zero
    localparam int unsigned FLAG_S = 2;                 // sign
    localparam int unsigned FLAG_V = 3;                 // signed overflow

    localparam flags_t FLAGS_ARITH = 4'b1111;           // add/sub family touch all flags
    localparam flags_t FLAGS_LOGIC = 4'b0110;           // bitwise ops touch Z and S only

    // opcodes 8..11 are reserved
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        ADC    = 4'd1,                                  // add with C flag
        SUB    = 4'd2,
        SBC    = 4'd3,                                  // subtract with borrow
        AND    = 4'd4,
        ANDN   = 4'd5,                                  // a & ~b
        OR     = 4'd6,
        XOR    = 4'd7,
        MUL    = 4'd12,                                 // low word of product
        MULHUU = 4'd13,                                 // high word, u * u
        MULHSU = 4'd14,                                 // high word, s * u
        MULHSS = 4'd15                                  // high word, s * s
    } alu_op_t;

endpackage
